// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // major opcode, instr[6:2]
  typedef enum logic [4:0] {
    opc_load   = 5'b00000,
    opc_op_imm = 5'b00100,
    opc_auipc  = 5'b00101,
    opc_store  = 5'b01000,
    opc_op     = 5'b01100,
    opc_lui    = 5'b01101,
    opc_branch = 5'b11000,
    opc_jalr   = 5'b11001,
    opc_jal    = 5'b11011,
    opc_system = 5'b11100
  } opcode_e;

  // illegal must stay the last encoding
  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu,
    cls_system,
    cls_illegal
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef struct packed {
    op_class_e             op_class;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    logic                  use_imm;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] link;
    logic [xlen-1:0] target_pc;
    logic [xlen-1:0] mem_addr;
    logic [1:0]      byte_off;
    logic [xlen-1:0] store_data;
    logic [3:0]      wstrb;
    logic            misaligned;
  } exec_t;

endpackage

`default_nettype wire

// File: rv_decode.sv
`default_nettype none

module rv_decode (
  input  wire  [rv_pkg::xlen-1:0] instr,
  output rv_pkg::decoded_t        dec
);

  rv_pkg::opcode_e  opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             alt;
  logic [31:0]      imm_i;
  logic [31:0]      imm_s;
  logic [31:0]      imm_b;
  logic [31:0]      imm_u;
  logic [31:0]      imm_j;

  assign opcode = rv_pkg::opcode_e'(instr[6:2]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  // sub and sra variants
  assign alt    = funct7 == 7'b0100000;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return sub_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    dec.op_class = rv_pkg::cls_illegal;
    dec.alu_op   = rv_pkg::alu_add;
    dec.funct3   = funct3;
    dec.use_imm  = 1'b0;
    dec.rd       = instr[11:7];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.imm      = '0;
    // compressed words fall through as illegal
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        rv_pkg::opc_lui: begin
          dec.op_class = rv_pkg::cls_lui;
          dec.imm      = imm_u;
        end
        rv_pkg::opc_auipc: begin
          dec.op_class = rv_pkg::cls_auipc;
          dec.imm      = imm_u;
        end
        rv_pkg::opc_jal: begin
          dec.op_class = rv_pkg::cls_jal;
          dec.imm      = imm_j;
        end
        rv_pkg::opc_jalr: begin
          dec.imm = imm_i;
          if (funct3 == 3'b000) dec.op_class = rv_pkg::cls_jalr;
        end
        rv_pkg::opc_branch: begin
          dec.imm = imm_b;
          if (funct3[2:1] != 2'b01) dec.op_class = rv_pkg::cls_branch;
        end
        rv_pkg::opc_load: begin
          dec.imm = imm_i;
          if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
            dec.op_class = rv_pkg::cls_load;
          end
        end
        rv_pkg::opc_store: begin
          dec.imm = imm_s;
          if (funct3 inside {3'b000, 3'b001, 3'b010}) dec.op_class = rv_pkg::cls_store;
        end
        rv_pkg::opc_op_imm: begin
          dec.imm     = imm_i;
          dec.use_imm = 1'b1;
          dec.alu_op  = alu_sel(funct3, alt && funct3 == 3'b101);
          // shift immediates carry funct7 in the upper bits
          if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'd0 ||
              (alt && funct3 == 3'b101)) begin
            dec.op_class = rv_pkg::cls_alu;
          end
        end
        rv_pkg::opc_op: begin
          dec.alu_op = alu_sel(funct3, alt);
          if (funct7 == 7'd0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
            dec.op_class = rv_pkg::cls_alu;
          end
        end
        rv_pkg::opc_system: begin
          // only ecall and ebreak
          if (instr[31:21] == 11'd0 && instr[19:7] == 13'd0) dec.op_class = rv_pkg::cls_system;
        end
        default: dec.op_class = rv_pkg::cls_illegal;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  wire                           clk,
  input  wire                           reset,
  input  wire  [rv_pkg::reg_addr_w-1:0] rs1,
  input  wire  [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  wire                           we,
  input  wire  [rv_pkg::reg_addr_w-1:0] rd,
  input  wire  [rv_pkg::xlen-1:0]       rd_data
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:(1 << rv_pkg::reg_addr_w) - 1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < (1 << rv_pkg::reg_addr_w); i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: rv_execute.sv
`default_nettype none

module rv_execute (
  input  wire  rv_pkg::decoded_t  dec,
  input  wire  [rv_pkg::xlen-1:0] pc,
  input  wire  [rv_pkg::xlen-1:0] rs1_data,
  input  wire  [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::exec_t           ex
);

  logic [31:0] operand_b;
  logic [4:0]  shamt;
  logic [31:0] alu_out;
  logic [31:0] pc_plus_imm;
  logic [31:0] pc_plus_4;
  logic [31:0] rs1_plus_imm;
  logic        take;
  logic        is_mem;

  assign operand_b    = dec.use_imm ? dec.imm : rs2_data;
  assign shamt        = operand_b[4:0];
  assign pc_plus_imm  = pc + dec.imm;
  assign pc_plus_4    = pc + 32'd4;
  // shared by jalr and load/store addressing
  assign rs1_plus_imm = rs1_data + dec.imm;
  assign is_mem       = dec.op_class == rv_pkg::cls_load || dec.op_class == rv_pkg::cls_store;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:  alu_out = rs1_data + operand_b;
      rv_pkg::alu_sub:  alu_out = rs1_data - operand_b;
      rv_pkg::alu_sll:  alu_out = rs1_data << shamt;
      rv_pkg::alu_slt:  alu_out = {31'd0, $signed(rs1_data) < $signed(operand_b)};
      rv_pkg::alu_sltu: alu_out = {31'd0, rs1_data < operand_b};
      rv_pkg::alu_xor:  alu_out = rs1_data ^ operand_b;
      rv_pkg::alu_srl:  alu_out = rs1_data >> shamt;
      rv_pkg::alu_sra:  alu_out = $unsigned($signed(rs1_data) >>> shamt);
      rv_pkg::alu_or:   alu_out = rs1_data | operand_b;
      default:          alu_out = rs1_data & operand_b;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  take = rs1_data == rs2_data;
      3'b001:  take = rs1_data != rs2_data;
      3'b100:  take = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  take = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  take = rs1_data < rs2_data;
      default: take = rs1_data >= rs2_data;
    endcase
  end

  always_comb begin
    ex.link = pc_plus_4;

    case (dec.op_class)
      rv_pkg::cls_lui:   ex.alu_result = dec.imm;
      rv_pkg::cls_auipc: ex.alu_result = pc_plus_imm;
      default:           ex.alu_result = alu_out;
    endcase

    case (dec.op_class)
      rv_pkg::cls_jal:    ex.target_pc = pc_plus_imm;
      rv_pkg::cls_jalr:   ex.target_pc = {rs1_plus_imm[31:1], 1'b0};
      rv_pkg::cls_branch: ex.target_pc = take ? pc_plus_imm : pc_plus_4;
      default:            ex.target_pc = pc_plus_4;
    endcase

    ex.mem_addr = {rs1_plus_imm[31:2], 2'b00};
    ex.byte_off = rs1_plus_imm[1:0];

    // replicate store data into every lane, strobe picks the lane
    case (dec.funct3[1:0])
      2'b00: begin
        ex.store_data = {4{rs2_data[7:0]}};
        ex.wstrb      = 4'b0001 << rs1_plus_imm[1:0];
      end
      2'b01: begin
        ex.store_data = {2{rs2_data[15:0]}};
        ex.wstrb      = rs1_plus_imm[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        ex.store_data = rs2_data;
        ex.wstrb      = 4'b1111;
      end
    endcase
    if (dec.op_class != rv_pkg::cls_store) ex.wstrb = 4'b0000;

    ex.misaligned = is_mem &&
                    ((dec.funct3[1:0] == 2'b10 && rs1_plus_imm[1:0] != 2'b00) ||
                     (dec.funct3[1:0] == 2'b01 && rs1_plus_imm[0]));
  end

endmodule

`default_nettype wire

// File: rv_result.sv
`default_nettype none

module rv_result (
  input  wire  rv_pkg::decoded_t  dec,
  input  wire  rv_pkg::exec_t     ex,
  input  wire  [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] wb_data,
  output logic                    wb_en
);

  logic [7:0]  load_byte;
  logic [15:0] load_half;
  logic [31:0] load_value;

  always_comb begin
    case (ex.byte_off)
      2'b00:   load_byte = mem_rdata[7:0];
      2'b01:   load_byte = mem_rdata[15:8];
      2'b10:   load_byte = mem_rdata[23:16];
      default: load_byte = mem_rdata[31:24];
    endcase
  end

  assign load_half = ex.byte_off[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  // funct3 bit 2 selects zero extension
  always_comb begin
    case (dec.funct3)
      3'b000:  load_value = {{24{load_byte[7]}}, load_byte};
      3'b001:  load_value = {{16{load_half[15]}}, load_half};
      3'b100:  load_value = {24'd0, load_byte};
      3'b101:  load_value = {16'd0, load_half};
      default: load_value = mem_rdata;
    endcase
  end

  always_comb begin
    case (dec.op_class)
      rv_pkg::cls_load: wb_data = load_value;
      rv_pkg::cls_jal,
      rv_pkg::cls_jalr: wb_data = ex.link;
      default:          wb_data = ex.alu_result;
    endcase
  end

  assign wb_en = dec.op_class inside {rv_pkg::cls_lui, rv_pkg::cls_auipc, rv_pkg::cls_jal,
                                      rv_pkg::cls_jalr, rv_pkg::cls_load, rv_pkg::cls_alu};

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core (
  input  wire                     clk,
  input  wire                     reset,
  output logic                    mem_valid,
  output logic                    mem_instr,
  input  wire                     mem_ready,
  output logic [rv_pkg::xlen-1:0] mem_addr,
  output logic [rv_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]              mem_wstrb,
  input  wire  [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    trap
);

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_fetch,
    st_decode,
    st_execute,
    st_mem_wait,
    st_check_pc,
    st_write_back,
    st_trapped
  } state_e;

  state_e                  state;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] instr;
  logic [rv_pkg::xlen-1:0] load_data;
  rv_pkg::decoded_t        dec;
  rv_pkg::decoded_t        dec_q;
  rv_pkg::exec_t           ex;
  rv_pkg::exec_t           ex_q;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic                    wb_en;
  logic                    exec_fault;

  rv_decode u_decode (.instr(instr), .dec(dec));

  rv_regfile u_regfile (
    .clk(clk), .reset(reset),
    .rs1(dec_q.rs1), .rs2(dec_q.rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(state == st_write_back && wb_en), .rd(dec_q.rd), .rd_data(wb_data)
  );

  rv_execute u_execute (
    .dec(dec_q), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .ex(ex)
  );

  rv_result u_result (
    .dec(dec_q), .ex(ex_q), .mem_rdata(load_data), .wb_data(wb_data), .wb_en(wb_en)
  );

  assign exec_fault = dec_q.op_class == rv_pkg::cls_illegal ||
                      dec_q.op_class == rv_pkg::cls_system || ex.misaligned;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_fetch;
      pc        <= rv_pkg::reset_pc;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_addr  <= '0;
      mem_wdata <= '0;
      mem_wstrb <= '0;
      trap      <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_addr  <= pc;
          mem_wstrb <= '0;
          state     <= st_wait_fetch;
        end
        st_wait_fetch: if (mem_ready) begin
          mem_valid <= 1'b0;
          instr     <= mem_rdata;
          state     <= st_decode;
        end
        st_decode: begin
          dec_q <= dec;
          state <= st_execute;
        end
        st_execute: begin
          ex_q <= ex;
          if (exec_fault) begin
            trap  <= 1'b1;
            state <= st_trapped;
          end else if (dec_q.op_class inside {rv_pkg::cls_load, rv_pkg::cls_store}) begin
            mem_valid <= 1'b1;
            mem_instr <= 1'b0;
            mem_addr  <= ex.mem_addr;
            mem_wdata <= ex.store_data;
            mem_wstrb <= ex.wstrb;
            state     <= st_mem_wait;
          end else if (dec_q.op_class inside {rv_pkg::cls_jal, rv_pkg::cls_jalr,
                                              rv_pkg::cls_branch}) begin
            state <= st_check_pc;
          end else begin
            pc    <= ex.link;
            state <= st_write_back;
          end
        end
        st_mem_wait: if (mem_ready) begin
          mem_valid <= 1'b0;
          mem_wstrb <= '0;
          load_data <= mem_rdata;
          pc        <= ex_q.link;
          state     <= (dec_q.op_class == rv_pkg::cls_load) ? st_write_back : st_fetch;
        end
        // no compressed support, so targets must be word aligned
        st_check_pc: if (|ex_q.target_pc[1:0]) begin
          trap  <= 1'b1;
          state <= st_trapped;
        end else begin
          pc    <= ex_q.target_pc;
          state <= (dec_q.op_class == rv_pkg::cls_branch) ? st_fetch : st_write_back;
        end
        st_write_back: state <= st_fetch;
        st_trapped:    trap  <= 1'b1;
      endcase
    end
  end

  req_held: assert property (@(posedge clk) disable iff (reset)
    (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_instr) && $stable(mem_addr) &&
                                   $stable(mem_wdata) && $stable(mem_wstrb)));

  // once trapped the core stays quiet on the memory port
  trap_sticky: assert property (@(posedge clk) disable iff (reset)
    trap |=> (trap && !mem_valid));

endmodule

`default_nettype wire

// File: tb_rv_programs.svh
// each entry gives name, word at 0x100 after the run, strobe of its last store, trap, program
task automatic build_table();
  add_test("alu_ops", 32'hffff_ffec, 4'hf, 1'b1, '{alu_i(0, 1, 0, 12'hffb), alu_i(0, 2, 0, 3),
    alu_r(0, 2, 3, 1, 2), alu_r(0, 3, 4, 1, 2), alu_r(7'h20, 0, 5, 2, 1), alu_r(0, 1, 5, 5, 3),
    alu_r(0, 4, 5, 5, 1), alu_r(0, 0, 5, 5, 3), alu_r(0, 6, 5, 5, 4), sw100(5), ecall});
  add_test("shifts_lui", 32'h0800_01ff, 4'hf, 1'b1, '{upper(7'h37, 1, 20'h80000),
    alu_i(0, 2, 0, 4), alu_r(7'h20, 5, 3, 1, 2), alu_r(0, 5, 4, 1, 2), alu_i(5, 3, 3, 12'h404),
    alu_r(0, 7, 5, 3, 4), alu_i(4, 5, 5, 12'h0ff), alu_i(6, 5, 5, 12'h100), sw100(5), ecall});
  add_test("auipc", 32'h0001_2004, 4'hf, 1'b1, '{alu_i(0, 1, 0, 1),
    upper(7'h17, 5, 20'h00012), sw100(5), ecall});
  // x1 = -1, x2 = 1; each addi that runs sets one bit of x5
  add_test("branch_taken_a", 32'h0, 4'hf, 1'b1, '{alu_i(0, 1, 0, 12'hfff), alu_i(0, 2, 0, 1),
    branch(0, 1, 1, 8), alu_i(0, 5, 5, 1), branch(1, 1, 2, 8), alu_i(0, 5, 5, 2),
    branch(4, 1, 2, 8), alu_i(0, 5, 5, 4), sw100(5), ecall});
  add_test("branch_taken_b", 32'h0, 4'hf, 1'b1, '{alu_i(0, 1, 0, 12'hfff), alu_i(0, 2, 0, 1),
    branch(5, 2, 1, 8), alu_i(0, 5, 5, 1), branch(6, 2, 1, 8), alu_i(0, 5, 5, 2),
    branch(7, 1, 2, 8), alu_i(0, 5, 5, 4), sw100(5), ecall});
  add_test("branch_not_a", 32'h7, 4'hf, 1'b1, '{alu_i(0, 1, 0, 12'hfff), alu_i(0, 2, 0, 1),
    branch(0, 1, 2, 8), alu_i(0, 5, 5, 1), branch(1, 1, 1, 8), alu_i(0, 5, 5, 2),
    branch(4, 2, 1, 8), alu_i(0, 5, 5, 4), sw100(5), ecall});
  add_test("branch_not_b", 32'h7, 4'hf, 1'b1, '{alu_i(0, 1, 0, 12'hfff), alu_i(0, 2, 0, 1),
    branch(5, 1, 2, 8), alu_i(0, 5, 5, 1), branch(6, 1, 2, 8), alu_i(0, 5, 5, 2),
    branch(7, 2, 1, 8), alu_i(0, 5, 5, 4), sw100(5), ecall});
  // link 8 from jal plus link 16 from jalr
  add_test("jal_jalr", 32'h18, 4'hf, 1'b1, '{alu_i(0, 1, 0, 16), jal(5, 8),
    alu_i(0, 5, 0, 12'h7ff), jalr(6, 1, 4), alu_i(0, 5, 0, 0), alu_r(0, 0, 5, 5, 6),
    sw100(5), ecall});
  add_test("sb_lanes", 32'h4433_2211, 4'h8, 1'b1, '{alu_i(0, 1, 0, 12'h011),
    alu_i(0, 2, 0, 12'h022), alu_i(0, 3, 0, 12'h033), alu_i(0, 4, 0, 12'h044),
    store(0, 1, 0, 12'h100), store(0, 2, 0, 12'h101), store(0, 3, 0, 12'h102),
    store(0, 4, 0, 12'h103), ecall});
  add_test("sh_halves", 32'h0567_beef, 4'hc, 1'b1, '{upper(7'h37, 1, 20'h0000c),
    alu_i(0, 1, 1, 12'heef), alu_i(0, 2, 0, 12'h567), store(1, 1, 0, 12'h100),
    store(1, 2, 0, 12'h102), ecall});
  add_test("x0_store", 32'h0, 4'hf, 1'b1, '{alu_i(0, 0, 0, 12'h055), sw100(0), ecall});
  // data word at 0x200 holds bytes 7f 92 f1 80
  add_test("lb_offsets", 32'hffff_ff82, 4'hf, 1'b1, '{load(0, 1, 0, 12'h200),
    load(0, 2, 0, 12'h201), load(0, 3, 0, 12'h202), load(0, 4, 0, 12'h203),
    alu_r(0, 0, 5, 1, 2), alu_r(0, 0, 5, 5, 3), alu_r(0, 0, 5, 5, 4), sw100(5), ecall});
  add_test("lbu_offsets", 32'h0000_0282, 4'hf, 1'b1, '{load(4, 1, 0, 12'h200),
    load(4, 2, 0, 12'h201), load(4, 3, 0, 12'h202), load(4, 4, 0, 12'h203),
    alu_r(0, 0, 5, 1, 2), alu_r(0, 0, 5, 5, 3), alu_r(0, 0, 5, 5, 4), sw100(5), ecall});
  add_test("lh_lhu_lw", 32'h80f1_b95f, 4'hf, 1'b1, '{load(1, 1, 0, 12'h200),
    load(1, 2, 0, 12'h202), load(5, 3, 0, 12'h200), load(5, 4, 0, 12'h202),
    alu_r(0, 0, 5, 1, 2), alu_r(0, 0, 5, 5, 3), alu_r(0, 0, 5, 5, 4),
    load(2, 6, 0, 12'h200), alu_r(0, 0, 5, 5, 6), sw100(5), ecall});
  add_test("illegal_word", fill_word(8'd64), 4'h0, 1'b1, '{32'hffff_ffff, sw100(0), ecall});
  add_test("misaligned_lw", fill_word(8'd64), 4'h0, 1'b1, '{load(2, 1, 0, 12'h202),
    sw100(1), ecall});
  add_test("jalr_odd", fill_word(8'd64), 4'h0, 1'b1, '{alu_i(0, 1, 0, 7), jalr(0, 1, 0),
    sw100(1), ecall});
endtask

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;

  localparam int max_tests = 24;
  localparam logic [31:0] data_word = 32'h80f1_927f;
  localparam logic [31:0] ecall = 32'h0000_0073;

  logic        clk;
  logic        reset;
  logic        mem_valid;
  logic        mem_instr;
  logic        mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        trap;

  logic [31:0] mem [256];
  logic [31:0] rnd;
  logic [3:0]  last_strb;
  integer      seed = 32'hbf6b;
  int          wait_cnt;
  int          errors;
  int          failed_tests;
  int          num_tests;

  string       name_tab [max_tests];
  logic [31:0] prog_tab [max_tests][12];
  logic [31:0] word_tab [max_tests];
  logic [3:0]  strb_tab [max_tests];
  logic        trap_tab [max_tests];

  rv_core UUT (
    .clk(clk), .reset(reset),
    .mem_valid(mem_valid), .mem_instr(mem_instr), .mem_ready(mem_ready),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata), .trap(trap)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // instruction encoders
  function automatic logic [31:0] alu_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] alu_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] load(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                       logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'h03};
  endfunction

  function automatic logic [31:0] store(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] upper(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] jalr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'h67};
  endfunction

  function automatic logic [31:0] sw100(logic [4:0] rs2);
    return store(3'b010, rs2, 5'd0, 12'h100);
  endfunction

  function automatic logic [31:0] fill_word(logic [7:0] i);
    return {8'ha5, i, ~i, i ^ 8'h3c};
  endfunction

  task automatic add_test(input string name, input logic [31:0] exp_word,
                          input logic [3:0] exp_strb, input logic exp_trap,
                          input logic [31:0] words [$]);
    name_tab[num_tests] = name;
    word_tab[num_tests] = exp_word;
    strb_tab[num_tests] = exp_strb;
    trap_tab[num_tests] = exp_trap;
    for (int i = 0; i < 12; i++) begin
      prog_tab[num_tests][i] = (i < words.size()) ? words[i] : 32'h0;
    end
    num_tests++;
  endtask

  `include "tb_rv_programs.svh"

  task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  // memory answers each request after 0 to 3 cycles
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      wait_cnt  <= -1;
    end else if (mem_valid && mem_ready) begin
      mem_ready <= 1'b0;
      wait_cnt  <= -1;
      // programs lie below 0x100, data at 0x100 and up
      check("mem_instr", {31'd0, mem_instr}, {31'd0, mem_addr < 32'h100});
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) mem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
      if (mem_wstrb != 4'd0 && mem_addr == 32'h100) last_strb <= mem_wstrb;
    end else if (mem_valid) begin
      if (wait_cnt < 0) begin
        rnd = $random(seed);
        if (rnd[1:0] == 2'd0) begin
          mem_ready <= 1'b1;
          mem_rdata <= mem[mem_addr[9:2]];
        end else begin
          wait_cnt <= int'(rnd[1:0]) - 1;
        end
      end else if (wait_cnt == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[9:2]];
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  initial begin
    @(posedge clk);
    #(num_tests * 12 * 20 * 20);
    $display("timeout: the core did not reach trap in time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int errors_before;
    reset        = 1'b1;
    mem_ready    = 1'b0;
    mem_rdata    = 32'h0;
    errors       = 0;
    failed_tests = 0;
    num_tests    = 0;
    build_table();
    for (int t = 0; t < num_tests; t++) begin
      errors_before = errors;
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < 256; i++) mem[i] = fill_word(i[7:0]);
      for (int i = 0; i < 12; i++) mem[i] = prog_tab[t][i];
      mem[128] = data_word;
      last_strb = 4'd0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      while (trap !== 1'b1) @(posedge clk);
      // no request may follow a trap
      repeat (4) begin
        @(posedge clk);
        check("mem_valid", {31'd0, mem_valid}, 32'd0);
      end
      check("trap", {31'd0, trap}, {31'd0, trap_tab[t]});
      check("mem[0x100]", mem[64], word_tab[t]);
      check("mem_wstrb", {28'd0, last_strb}, {28'd0, strb_tab[t]});
      if (errors != errors_before) failed_tests++;
      $display("test %0d %s: %s", t, name_tab[t], (errors == errors_before) ? "ok" : "failed");
    end
    $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rv_pkg.sv
      - rv_decode.sv
      - rv_regfile.sv
      - rv_execute.sv
      - rv_result.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
